/* Bender.yml */
package:
  name: cp0_unit

sources:
  - include_dirs:
      - common
    files:
      - common/cp0_pkg.sv
      - src/exc_commit.sv
      - cp0/cp0_regs.sv
      - src/exc_redirect.sv
      - src/cp0_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/cp0_properties.sv
      - testbench/cp0_tb.sv

/* common/cp0_consts.svh */
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// CP0 register numbers (select 0)
`define CP0_BADVADDR 5'd8
`define CP0_COUNT    5'd9
`define CP0_COMPARE  5'd11
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14

// Cause.ExcCode values
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_OV   5'd12

// Fixed handler address as Bev is always 1
`define EXC_VECTOR 32'hBFC0_0380

// IM7..IM0, EXL, IE
`define STATUS_WMASK 32'h0000_FF03

// Only the software interrupt bits IP1..IP0
`define CAUSE_WMASK 32'h0000_0300

`endif

/* common/cp0_pkg.sv */
package cp0_pkg;

    // Register 12
    typedef struct packed {
        logic [8:0] zero_0;     // [31:23]
        logic       bev;        // [22] read-only and always 1
        logic [5:0] zero_1;     // [21:16]
        logic [7:0] im;         // [15:8] interrupt mask
        logic [5:0] zero_2;     // [7:2]
        logic       exl;        // [1]
        logic       ie;         // [0]
    } cp0_status_t;

    // Register 13
    typedef struct packed {
        logic        bd;        // [31] branch delay
        logic        ti;        // [30] timer interrupt
        logic [13:0] zero_0;    // [29:16]
        logic [7:0]  ip;        // [15:8] IP7..IP2 hardware, IP1..IP0 software
        logic        zero_1;    // [7]
        logic [4:0]  exc_code;  // [6:2]
        logic [1:0]  zero_2;    // [1:0]
    } cp0_cause_t;

    // MTC0 data seen either as a raw word or through a register layout
    typedef union packed {
        logic [31:0] raw;
        cp0_status_t status;
        cp0_cause_t  cause;
    } cp0_word_u;

    typedef struct packed {
        logic [31:0] epc;       // 14
        cp0_cause_t  cause;     // 13
        cp0_status_t status;    // 12
        logic [31:0] compare;   // 11
        logic [31:0] count;     // 9
        logic [31:0] bad_vaddr; // 8
    } cp0_state_t;

    // At most one retiring instruction per cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        in_delay_slot;
        logic        exc_valid;
        logic [4:0]  exc_code;
        logic [31:0] bad_vaddr;
        logic        eret;
        logic        mtc0;
        logic [4:0]  mtc0_addr;
        logic [31:0] mtc0_data;
    } retire_t;

    typedef enum logic [1:0] {
        ACT_NONE,
        ACT_EXC,
        ACT_ERET,
        ACT_WRITE
    } cp0_act_kind_t;

    typedef struct packed {
        cp0_act_kind_t kind;
        logic [31:0]   epc;             // Already adjusted for delay slot
        logic          bd;
        logic [4:0]    exc_code;
        logic          load_bad_vaddr;
        logic [31:0]   bad_vaddr;
        logic [4:0]    wr_addr;
        cp0_word_u     wr_data;
    } cp0_action_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

/* cp0/cp0_regs.sv */
`timescale 1ns/10ps
`include "cp0_consts.svh"

module cp0_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  cp0_pkg::cp0_action_t action,
    input  logic [5:0]           hw_int,
    input  logic [4:0]           ra,
    output logic [31:0]          rd,
    output cp0_pkg::cp0_state_t  state
);
    import cp0_pkg::*;

    logic [31:0] epc;
    logic [31:0] compare;
    logic [31:0] count;
    logic [31:0] bad_vaddr;
    cp0_status_t status;
    cp0_cause_t  cause;
    logic        count_sup;     // Count advances on every other edge
    logic        ti_next;

    logic take_exc;
    logic take_eret;
    logic wr_status;
    logic wr_cause;
    logic wr_compare;
    logic wr_count;
    logic wr_epc;

    cp0_word_u status_merge;
    cp0_word_u cause_merge;

    assign take_exc   = action.kind == ACT_EXC;
    assign take_eret  = action.kind == ACT_ERET;
    assign wr_status  = (action.kind == ACT_WRITE) && (action.wr_addr == `CP0_STATUS);
    assign wr_cause   = (action.kind == ACT_WRITE) && (action.wr_addr == `CP0_CAUSE);
    assign wr_compare = (action.kind == ACT_WRITE) && (action.wr_addr == `CP0_COMPARE);
    assign wr_count   = (action.kind == ACT_WRITE) && (action.wr_addr == `CP0_COUNT);
    assign wr_epc     = (action.kind == ACT_WRITE) && (action.wr_addr == `CP0_EPC);

    // Keep read-only bits, take writable ones from the MTC0 word
    always_comb begin
        status_merge.raw = (status & ~`STATUS_WMASK) | (action.wr_data.raw & `STATUS_WMASK);
        cause_merge.raw  = (cause & ~`CAUSE_WMASK) | (action.wr_data.raw & `CAUSE_WMASK);
    end

    // Compare write wins over a match in the same cycle
    always_comb begin
        if (wr_compare) begin
            ti_next = 1'b0;
        end else if (compare != 32'd0 && count == compare) begin
            ti_next = 1'b1;
        end else begin
            ti_next = cause.ti;
        end
    end

    always_comb begin
        case (ra)
            `CP0_BADVADDR: rd = bad_vaddr;
            `CP0_COUNT:    rd = count;
            `CP0_COMPARE:  rd = compare;
            `CP0_STATUS:   rd = status;
            `CP0_CAUSE:    rd = cause;
            `CP0_EPC:      rd = epc;
            default:       rd = 32'd0;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count     <= 32'd0;
            count_sup <= 1'b0;
        end else begin
            count_sup <= ~count_sup;
            if (wr_count) begin
                count <= action.wr_data.raw;
            end else begin
                count <= count + {31'd0, count_sup};
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            compare <= 32'd0;
        end else if (wr_compare) begin
            compare <= action.wr_data.raw;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            status     <= '0;
            status.bev <= 1'b1;
        end else if (take_exc) begin
            status.exl <= 1'b1;
        end else if (take_eret) begin
            status.exl <= 1'b0;
        end else if (wr_status) begin
            status <= status_merge.status;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cause <= '0;
        end else begin
            cause.ti      <= ti_next;
            cause.ip[7:2] <= {hw_int[5] | ti_next, hw_int[4:0]};   // Timer shares IP7
            if (take_exc) begin
                cause.bd       <= action.bd;
                cause.exc_code <= action.exc_code;
            end
            if (wr_cause) begin
                cause.ip[1:0] <= cause_merge.cause.ip[1:0];
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            epc <= 32'd0;
        end else if (take_exc) begin
            epc <= action.epc;
        end else if (wr_epc) begin
            epc <= action.wr_data.raw;
        end
    end

    // Only address errors capture the faulting address
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            bad_vaddr <= 32'd0;
        end else if (take_exc && action.load_bad_vaddr) begin
            bad_vaddr <= action.bad_vaddr;
        end
    end

    assign state = '{
        epc:       epc,
        cause:     cause,
        status:    status,
        compare:   compare,
        count:     count,
        bad_vaddr: bad_vaddr
    };

endmodule

/* src/cp0_unit.sv */
`timescale 1ns/10ps

module cp0_unit (
    input  logic               clk,
    input  logic               reset,
    input  cp0_pkg::retire_t   retire,
    input  logic [5:0]         hw_int,
    input  logic [4:0]         ra,
    output logic [31:0]        rd,
    output cp0_pkg::redirect_t redirect,
    output logic               int_pending
);
    import cp0_pkg::*;

    cp0_action_t action;    // Resolved event for this cycle
    cp0_state_t  state;

    exc_commit exc_commit_i (
        .clk         (clk),
        .reset       (reset),
        .retire      (retire),
        .int_pending (int_pending),
        .action      (action)
    );

    cp0_regs cp0_regs_i (
        .clk    (clk),
        .reset  (reset),
        .action (action),
        .hw_int (hw_int),
        .ra     (ra),
        .rd     (rd),
        .state  (state)
    );

    exc_redirect exc_redirect_i (
        .clk         (clk),
        .reset       (reset),
        .action      (action),
        .state       (state),
        .int_pending (int_pending),
        .redirect    (redirect)
    );

endmodule

/* src/exc_commit.sv */
`timescale 1ns/10ps
`include "cp0_consts.svh"

module exc_commit (
    input  logic                 clk,
    input  logic                 reset,
    input  cp0_pkg::retire_t     retire,
    input  logic                 int_pending,
    output cp0_pkg::cp0_action_t action
);
    import cp0_pkg::*;

    logic        int_taken;     // Interrupt accepted last cycle
    logic        take_int;
    logic        wr_legal;
    logic        addr_exc;
    logic [31:0] epc_value;

    assign take_int  = retire.valid && int_pending && !int_taken;
    assign epc_value = retire.in_delay_slot ? retire.pc - 32'd4 : retire.pc;
    assign addr_exc  = (retire.exc_code == `EXC_ADEL) || (retire.exc_code == `EXC_ADES);

    // Only writable registers turn into a write action
    always_comb begin
        case (retire.mtc0_addr)
            `CP0_COMPARE, `CP0_COUNT, `CP0_STATUS, `CP0_CAUSE, `CP0_EPC: wr_legal = 1'b1;
            default: wr_legal = 1'b0;
        endcase
    end

    always_comb begin
        action.kind           = ACT_NONE;
        action.epc            = epc_value;
        action.bd             = retire.in_delay_slot;
        action.exc_code       = retire.exc_code;
        action.load_bad_vaddr = 1'b0;
        action.bad_vaddr      = retire.bad_vaddr;
        action.wr_addr        = retire.mtc0_addr;
        action.wr_data.raw    = retire.mtc0_data;

        if (take_int) begin
            // Instruction is dropped and EPC points at it
            action.kind     = ACT_EXC;
            action.exc_code = `EXC_INT;
        end else if (retire.valid && retire.exc_valid) begin
            action.kind           = ACT_EXC;
            action.load_bad_vaddr = addr_exc;
        end else if (retire.valid && retire.eret) begin
            action.kind = ACT_ERET;
        end else if (retire.valid && retire.mtc0 && wr_legal) begin
            action.kind = ACT_WRITE;
        end
    end

    // Blocks a back-to-back interrupt while EXL settles
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            int_taken <= 1'b0;
        end else begin
            int_taken <= take_int;
        end
    end

endmodule

/* src/exc_redirect.sv */
`timescale 1ns/10ps
`include "cp0_consts.svh"

module exc_redirect (
    input  logic                 clk,
    input  logic                 reset,
    input  cp0_pkg::cp0_action_t action,
    input  cp0_pkg::cp0_state_t  state,
    output logic                 int_pending,
    output cp0_pkg::redirect_t   redirect
);
    import cp0_pkg::*;

    logic        redirect_valid;
    logic [31:0] redirect_target;
    logic        take_exc;
    logic        take_eret;

    assign take_exc  = action.kind == ACT_EXC;
    assign take_eret = action.kind == ACT_ERET;

    // Enabled, not in a handler, and some unmasked request
    assign int_pending = state.status.ie && !state.status.exl
                         && |(state.cause.ip & state.status.im);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take_exc || take_eret;    // One-cycle pulse
        end
    end

    // state.epc here is still the value before this cycle's update
    always_ff @(posedge clk) begin
        if (take_eret) begin
            redirect_target <= state.epc;
        end else if (take_exc) begin
            redirect_target <= `EXC_VECTOR;
        end
    end

    assign redirect = '{valid: redirect_valid, target: redirect_target};

endmodule

/* testbench/cp0_properties.sv */
`timescale 1ns/10ps

module cp0_properties (
    input logic                clk,
    input logic                reset,
    input cp0_pkg::redirect_t  redirect,
    input logic                int_pending,
    input cp0_pkg::cp0_state_t state
);

    // Redirect is a one-cycle pulse
    redirect_single: assert property (
        @(posedge clk) disable iff (reset)
        redirect.valid |=> !redirect.valid
    ) else $error("redirect valid in two consecutive cycles");

    redirect_quiet_in_reset: assert property (
        @(posedge clk) reset |-> !redirect.valid
    ) else $error("redirect valid while reset is asserted");

    // No interrupt request outside enabled, non-handler mode
    pending_needs_ie: assert property (
        @(posedge clk) disable iff (reset)
        int_pending |-> (state.status.ie && !state.status.exl)
    ) else $error("int_pending high without IE set and EXL clear");

endmodule

bind cp0_unit cp0_properties cp0_properties_i (
    .clk         (clk),
    .reset       (reset),
    .redirect    (redirect),
    .int_pending (int_pending),
    .state       (state)
);

/* testbench/cp0_tb.sv */
`timescale 1ns/10ps
`include "cp0_consts.svh"

module cp0_tb;
    import cp0_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int SWEEP_CYCLES  = 32;
    localparam int TIMER_CYCLES  = 24;
    localparam int RANDOM_CYCLES = 3000;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + SWEEP_CYCLES + TIMER_CYCLES + 16
                                   + RANDOM_CYCLES;

    logic        clk;
    logic        reset;
    retire_t     retire_in;
    logic [5:0]  hw_int;
    logic [4:0]  ra;
    logic [31:0] rd;
    redirect_t   redirect;
    logic        int_pending;

    logic [31:0] lfsr;

    // Reference model state
    logic [31:0] m_epc;
    logic [31:0] m_compare;
    logic [31:0] m_count;
    logic        m_count_ph;    // Count moves when this is 1
    logic [31:0] m_bad_vaddr;
    cp0_status_t m_status;
    cp0_cause_t  m_cause;
    logic        m_int_taken;
    logic        m_redir_valid;
    logic [31:0] m_redir_target;

    cp0_unit cp0_unit_i (
        .clk         (clk),
        .reset       (reset),
        .retire      (retire_in),
        .hw_int      (hw_int),
        .ra          (ra),
        .rd          (rd),
        .redirect    (redirect),
        .int_pending (int_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] addr_pick(input logic [2:0] sel);
        case (sel)
            3'd0: return `CP0_BADVADDR;
            3'd1: return `CP0_COUNT;
            3'd2: return `CP0_COMPARE;
            3'd3: return `CP0_STATUS;
            3'd4: return `CP0_CAUSE;
            3'd5: return `CP0_EPC;
            3'd6: return `CP0_STATUS;
            default: return 5'd3;   // Unmapped
        endcase
    endfunction

    function automatic logic [4:0] exc_pick(input logic [2:0] sel);
        case (sel)
            3'd0: return `EXC_ADEL;
            3'd1: return `EXC_ADES;
            3'd2: return `EXC_SYS;
            3'd3: return `EXC_BP;
            3'd4: return `EXC_RI;
            3'd5: return `EXC_OV;
            3'd6: return `EXC_ADEL;
            default: return `EXC_SYS;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic model_int_pending();
        return m_status.ie && !m_status.exl && (|(m_cause.ip & m_status.im));
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] addr);
        case (addr)
            `CP0_BADVADDR: return m_bad_vaddr;
            `CP0_COUNT:    return m_count;
            `CP0_COMPARE:  return m_compare;
            `CP0_STATUS:   return m_status;
            `CP0_CAUSE:    return m_cause;
            `CP0_EPC:      return m_epc;
            default:       return 32'd0;
        endcase
    endfunction

    task automatic model_reset();
        m_epc          = '0;
        m_compare      = '0;
        m_count        = '0;
        m_count_ph     = 1'b0;
        m_bad_vaddr    = '0;
        m_status       = '0;
        m_status.bev   = 1'b1;
        m_cause        = '0;
        m_int_taken    = 1'b0;
        m_redir_valid  = 1'b0;
        m_redir_target = '0;
    endtask

    // Advance the model across the coming rising edge
    task automatic model_step();
        logic        take_int;
        logic        is_exc;
        logic        is_eret;
        logic        is_write;
        logic [4:0]  code;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        ti_n;
        take_int = retire_in.valid && model_int_pending() && !m_int_taken;
        is_exc   = take_int || (retire_in.valid && retire_in.exc_valid);
        is_eret  = !is_exc && retire_in.valid && retire_in.eret;
        is_write = !is_exc && !is_eret && retire_in.valid && retire_in.mtc0;
        code     = take_int ? `EXC_INT : retire_in.exc_code;
        waddr    = retire_in.mtc0_addr;
        wdata    = retire_in.mtc0_data;

        if (is_write && waddr == `CP0_COMPARE) begin
            ti_n = 1'b0;
        end else if (m_compare != 32'd0 && m_count == m_compare) begin
            ti_n = 1'b1;
        end else begin
            ti_n = m_cause.ti;
        end

        m_redir_valid = is_exc || is_eret;
        if (is_eret) begin
            m_redir_target = m_epc;     // EPC before this edge
        end else if (is_exc) begin
            m_redir_target = `EXC_VECTOR;
        end
        m_int_taken = take_int;

        if (is_write && waddr == `CP0_COUNT) begin
            m_count = wdata;
        end else begin
            m_count = m_count + {31'd0, m_count_ph};
        end
        m_count_ph = !m_count_ph;
        if (is_write && waddr == `CP0_COMPARE) begin
            m_compare = wdata;
        end

        m_cause.ti      = ti_n;
        m_cause.ip[7:2] = {hw_int[5] | ti_n, hw_int[4:0]};
        if (is_write && waddr == `CP0_CAUSE) begin
            m_cause.ip[1:0] = wdata[9:8];
        end

        if (is_exc) begin
            m_cause.bd       = retire_in.in_delay_slot;
            m_cause.exc_code = code;
            m_status.exl     = 1'b1;
            m_epc = retire_in.in_delay_slot ? retire_in.pc - 32'd4 : retire_in.pc;
            if (code == `EXC_ADEL || code == `EXC_ADES) begin
                m_bad_vaddr = retire_in.bad_vaddr;
            end
        end else if (is_eret) begin
            m_status.exl = 1'b0;
        end else if (is_write && waddr == `CP0_STATUS) begin
            m_status.im  = wdata[15:8];
            m_status.exl = wdata[1];
            m_status.ie  = wdata[0];
        end else if (is_write && waddr == `CP0_EPC) begin
            m_epc = wdata;
        end
    endtask

    // Sample at the falling edge, then model the next rising edge
    task automatic next_cycle();
        @(negedge clk);
        check_value(rd, model_read(ra), $sformatf("rd of register %0d", ra));
        check_value({31'd0, int_pending}, {31'd0, model_int_pending()}, "int_pending");
        check_value({31'd0, redirect.valid}, {31'd0, m_redir_valid}, "redirect.valid");
        if (m_redir_valid) begin
            check_value(redirect.target, m_redir_target, "redirect.target");
        end
        model_step();
        @(posedge clk);
    endtask

    task automatic idle_cycle(input logic [4:0] rd_addr);
        retire_in <= '0;
        ra        <= rd_addr;
    endtask

    task automatic issue_mtc0(input logic [4:0] addr, input logic [31:0] data,
                              input logic [4:0] rd_addr);
        retire_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.pc        = 32'h8000_0100;
        r.mtc0      = 1'b1;
        r.mtc0_addr = addr;
        r.mtc0_data = data;
        retire_in <= r;
        ra        <= rd_addr;
    endtask

    task automatic issue_retire(input logic [31:0] pc, input logic eret,
                                input logic [4:0] rd_addr);
        retire_t r;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        r.eret  = eret;
        retire_in <= r;
        ra        <= rd_addr;
    endtask

    task automatic random_retire();
        retire_t r;
        r.valid         = (rand_bits(3) != 0) && !m_redir_valid;  // Flushed in redirect cycle
        r.pc            = rand_bits(30) << 2;
        r.in_delay_slot = rand_bits(1) != 0;
        r.exc_valid     = rand_bits(3) == 0;
        r.exc_code      = exc_pick(3'(rand_bits(3)));
        r.bad_vaddr     = rand_bits(32);
        r.eret          = rand_bits(2) == 0;
        r.mtc0          = rand_bits(1) != 0;
        r.mtc0_addr     = addr_pick(3'(rand_bits(3)));
        if (r.mtc0_addr == `CP0_COMPARE) begin
            r.mtc0_data = m_count + rand_bits(5) + 32'd1;   // Close enough to match
        end else begin
            r.mtc0_data = rand_bits(32);
        end
        retire_in <= r;
        if (rand_bits(3) == 0) begin
            hw_int <= 6'(rand_bits(6));
        end
        if (rand_bits(1) != 0) begin
            ra <= addr_pick(3'(rand_bits(3)));
        end else begin
            ra <= 5'(rand_bits(5));
        end
    endtask

    initial begin
        int i;
        reset     = 1'b1;
        retire_in = '0;
        hw_int    = '0;
        ra        = '0;
        lfsr      = 32'd92;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Read every address while idle
        for (i = 0; i < SWEEP_CYCLES; i++) begin
            idle_cycle(5'(i));
            next_cycle();
        end

        // Compare a few ticks ahead, then clear TI with a new Compare
        issue_mtc0(`CP0_COMPARE, m_count + 32'd3, `CP0_CAUSE);
        next_cycle();
        repeat (TIMER_CYCLES) begin
            idle_cycle(`CP0_CAUSE);
            next_cycle();
        end
        issue_mtc0(`CP0_COMPARE, m_count + 32'd100, `CP0_CAUSE);
        next_cycle();
        idle_cycle(`CP0_CAUSE);
        next_cycle();

        // IP2 interrupt, blocked under EXL, then ERET
        hw_int <= 6'b000001;
        issue_mtc0(`CP0_STATUS, 32'h0000_0401, `CP0_STATUS);
        next_cycle();
        idle_cycle(`CP0_CAUSE);
        next_cycle();
        issue_retire(32'h8000_0200, 1'b0, `CP0_EPC);
        next_cycle();
        issue_retire(32'h8000_0204, 1'b0, `CP0_STATUS);
        next_cycle();
        issue_retire(32'h8000_0380, 1'b1, `CP0_EPC);
        next_cycle();
        idle_cycle(`CP0_STATUS);
        next_cycle();
        issue_retire(32'h8000_0200, 1'b0, `CP0_CAUSE);
        next_cycle();
        hw_int <= '0;
        idle_cycle(`CP0_EPC);
        next_cycle();
        issue_retire(32'h8000_0390, 1'b1, `CP0_STATUS);
        next_cycle();
        idle_cycle(`CP0_STATUS);
        next_cycle();

        for (i = 0; i < RANDOM_CYCLES; i++) begin
            random_retire();
            next_cycle();
        end

        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* vlog.f */
+incdir+common
common/cp0_pkg.sv
src/exc_commit.sv
cp0/cp0_regs.sv
src/exc_redirect.sv
src/cp0_unit.sv
testbench/cp0_properties.sv
testbench/cp0_tb.sv
